// File: source/vfu_settings.svh
`ifndef VFU_SETTINGS_SVH
`define VFU_SETTINGS_SVH

// Lanes per VRF word
`define VFU_N_LANES 4

// Element width in bits
`define VFU_ELEN 32

// Architectural vector registers
`define VFU_NR_VREGS 32

// VRF words per vector register
`define VFU_WORDS_PER_VREG 4

// Instruction id bits
`define VFU_ID_WIDTH 3

// Result queue entries
`define VFU_FIFO_DEPTH 4

`endif

// File: source/vfu_pkg.sv
`include "vfu_settings.svh"

package vfu_pkg;

  // Data widths
  typedef logic [`VFU_ELEN-1:0]                 elem_t;
  typedef logic [`VFU_N_LANES*`VFU_ELEN-1:0]    word_t;
  typedef logic [`VFU_N_LANES*`VFU_ELEN/8-1:0]  be_t;
  typedef logic [`VFU_N_LANES-1:0]              lane_mask_t;

  // Register file addressing
  typedef logic [$clog2(`VFU_NR_VREGS)-1:0]                       vreg_t;
  typedef logic [$clog2(`VFU_NR_VREGS*`VFU_WORDS_PER_VREG)-1:0]   vreg_addr_t;

  // Elements per instruction from 1 up to a full register
  typedef logic [$clog2(`VFU_N_LANES*`VFU_WORDS_PER_VREG):0] vl_t;

  typedef logic [`VFU_ID_WIDTH-1:0] insn_id_t;

  // Integer operations on a (vs1 or rs1) and b (vs2)
  typedef enum logic [2:0] {
    VFU_ADD,
    VFU_SUB,
    VFU_AND,
    VFU_OR,
    VFU_XOR,
    VFU_MIN,
    VFU_MAXU,
    VFU_SLL
  } vfu_op_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_READ,
    SEQ_ISSUE
  } seq_state_e;

endpackage

// File: source/vfu_if.sv
`timescale 1ns/1ps

// One word of operands on its way to the integer lanes
interface vfu_issue_if;
  logic                  valid;
  logic                  ready;
  vfu_pkg::vfu_op_e      op;
  vfu_pkg::word_t        opa;
  vfu_pkg::word_t        opb;
  vfu_pkg::lane_mask_t   lanes;
  vfu_pkg::vreg_addr_t   waddr;
  vfu_pkg::insn_id_t     id;
  // Final word of the instruction
  logic                  last;

  modport src (output valid, op, opa, opb, lanes, waddr, id, last, input ready);
  modport dst (input valid, op, opa, opb, lanes, waddr, id, last, output ready);
endinterface

// One result word with its VRF write information
interface vfu_result_if;
  logic                  valid;
  logic                  ready;
  vfu_pkg::word_t        data;
  vfu_pkg::be_t          be;
  vfu_pkg::vreg_addr_t   waddr;
  vfu_pkg::insn_id_t     id;
  logic                  last;

  modport src (output valid, data, be, waddr, id, last, input ready);
  modport dst (input valid, data, be, waddr, id, last, output ready);
endinterface

// File: source/vfu_sequencer.sv
`timescale 1ns/1ps
`include "vfu_settings.svh"

module vfu_sequencer (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Request
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  vfu_pkg::vfu_op_e           req_op_i,
  input  vfu_pkg::vreg_t             req_vs1_i,
  input  vfu_pkg::vreg_t             req_vs2_i,
  input  vfu_pkg::vreg_t             req_vd_i,
  input  logic                       req_use_rs1_i,
  input  vfu_pkg::elem_t             req_rs1_i,
  input  vfu_pkg::vl_t               req_vl_i,
  input  vfu_pkg::insn_id_t          req_id_i,
  // VRF reads with vs2 on port 0 and vs1 on port 1
  output logic                 [1:0] vrf_re_o,
  output vfu_pkg::vreg_addr_t  [1:0] vrf_raddr_o,
  input  logic                 [1:0] vrf_rvalid_i,
  input  vfu_pkg::word_t       [1:0] vrf_rdata_i,
  vfu_issue_if.src                   issue_o
);

  ////////////////////
  // Request queue
  ////////////////////

  logic                q_valid;
  vfu_pkg::vfu_op_e    q_op;
  vfu_pkg::vreg_t      q_vs1;
  vfu_pkg::vreg_t      q_vs2;
  vfu_pkg::vreg_t      q_vd;
  logic                q_use_rs1;
  vfu_pkg::elem_t      q_rs1;
  vfu_pkg::vl_t        q_vl;
  vfu_pkg::insn_id_t   q_id;

  logic issue_fire;
  logic last_word;

  assign req_ready_o = !q_valid;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      q_valid <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      q_valid <= 1'b1;
    end else if (issue_fire && last_word) begin
      q_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      q_op      <= req_op_i;
      q_vs1     <= req_vs1_i;
      q_vs2     <= req_vs2_i;
      q_vd      <= req_vd_i;
      q_use_rs1 <= req_use_rs1_i;
      q_rs1     <= req_rs1_i;
      q_vl      <= req_vl_i;
      q_id      <= req_id_i;
    end
  end

  ////////////////////
  // Word sequencing
  ////////////////////

  vfu_pkg::seq_state_e                       state_q;
  logic [$clog2(`VFU_WORDS_PER_VREG)-1:0]    word_idx_q;
  vfu_pkg::vl_t                              remain_q;
  vfu_pkg::word_t                            opa_q;
  vfu_pkg::word_t                            opb_q;
  logic                                      got_a_q;
  logic                                      got_b_q;
  logic                                      a_done;
  logic                                      b_done;

  // Operand a is never read when the scalar replaces it
  assign vrf_re_o[0] = (state_q == vfu_pkg::SEQ_READ) && !got_b_q;
  assign vrf_re_o[1] = (state_q == vfu_pkg::SEQ_READ) && !got_a_q && !q_use_rs1;

  assign vrf_raddr_o[0] = vfu_pkg::vreg_addr_t'(q_vs2 * `VFU_WORDS_PER_VREG)
                          + vfu_pkg::vreg_addr_t'(word_idx_q);
  assign vrf_raddr_o[1] = vfu_pkg::vreg_addr_t'(q_vs1 * `VFU_WORDS_PER_VREG)
                          + vfu_pkg::vreg_addr_t'(word_idx_q);

  assign b_done = got_b_q || (vrf_re_o[0] && vrf_rvalid_i[0]);
  assign a_done = q_use_rs1 || got_a_q || (vrf_re_o[1] && vrf_rvalid_i[1]);

  assign last_word  = remain_q <= vfu_pkg::vl_t'(`VFU_N_LANES);
  assign issue_fire = issue_o.valid && issue_o.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= vfu_pkg::SEQ_IDLE;
      word_idx_q <= '0;
      remain_q   <= '0;
      got_a_q    <= 1'b0;
      got_b_q    <= 1'b0;
    end else begin
      unique case (state_q)
        vfu_pkg::SEQ_IDLE: begin
          if (q_valid) begin
            state_q    <= vfu_pkg::SEQ_READ;
            word_idx_q <= '0;
            remain_q   <= q_vl;
          end
        end
        vfu_pkg::SEQ_READ, vfu_pkg::SEQ_ISSUE: begin
          if (issue_fire) begin
            state_q    <= last_word ? vfu_pkg::SEQ_IDLE : vfu_pkg::SEQ_READ;
            word_idx_q <= word_idx_q + 1'b1;
            remain_q   <= remain_q - vfu_pkg::vl_t'(`VFU_N_LANES);
            got_a_q    <= 1'b0;
            got_b_q    <= 1'b0;
          end else begin
            // Operands complete but the lanes are busy
            if (a_done && b_done) state_q <= vfu_pkg::SEQ_ISSUE;
            if (vrf_re_o[0] && vrf_rvalid_i[0]) got_b_q <= 1'b1;
            if (vrf_re_o[1] && vrf_rvalid_i[1]) got_a_q <= 1'b1;
          end
        end
        default: state_q <= vfu_pkg::SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (vrf_re_o[0] && vrf_rvalid_i[0]) opb_q <= vrf_rdata_i[0];
    if (vrf_re_o[1] && vrf_rvalid_i[1]) opa_q <= vrf_rdata_i[1];
  end

  ////////////////////
  // Issue word
  ////////////////////

  assign issue_o.valid = (state_q != vfu_pkg::SEQ_IDLE) && a_done && b_done;
  assign issue_o.op    = q_op;
  assign issue_o.opa   = q_use_rs1 ? {`VFU_N_LANES{q_rs1}} : (got_a_q ? opa_q : vrf_rdata_i[1]);
  assign issue_o.opb   = got_b_q ? opb_q : vrf_rdata_i[0];
  assign issue_o.waddr = vfu_pkg::vreg_addr_t'(q_vd * `VFU_WORDS_PER_VREG)
                         + vfu_pkg::vreg_addr_t'(word_idx_q);
  assign issue_o.id    = q_id;
  assign issue_o.last  = last_word;

  // Lane i is live while more than i elements remain
  always_comb begin
    for (int i = 0; i < `VFU_N_LANES; i++) begin
      issue_o.lanes[i] = remain_q > vfu_pkg::vl_t'(i);
    end
  end

endmodule

// File: source/vfu_ipu.sv
`timescale 1ns/1ps
`include "vfu_settings.svh"

module vfu_ipu (
  input  logic       clk_i,
  input  logic       rst_n_i,
  vfu_issue_if.dst   issue_i,
  vfu_result_if.src  result_o
);

  vfu_pkg::word_t      res;
  vfu_pkg::be_t        be;
  logic                out_valid_q;
  vfu_pkg::word_t      data_q;
  vfu_pkg::be_t        be_q;
  vfu_pkg::vreg_addr_t waddr_q;
  vfu_pkg::insn_id_t   id_q;
  logic                last_q;

  ////////////////////
  // Lanes
  ////////////////////

  always_comb begin : lane_proc
    vfu_pkg::elem_t a;
    vfu_pkg::elem_t b;
    res = '0;
    be  = '0;
    for (int i = 0; i < `VFU_N_LANES; i++) begin
      a = issue_i.opa[i*`VFU_ELEN +: `VFU_ELEN];
      b = issue_i.opb[i*`VFU_ELEN +: `VFU_ELEN];
      unique case (issue_i.op)
        vfu_pkg::VFU_ADD:  res[i*`VFU_ELEN +: `VFU_ELEN] = a + b;
        vfu_pkg::VFU_SUB:  res[i*`VFU_ELEN +: `VFU_ELEN] = a - b;
        vfu_pkg::VFU_AND:  res[i*`VFU_ELEN +: `VFU_ELEN] = a & b;
        vfu_pkg::VFU_OR:   res[i*`VFU_ELEN +: `VFU_ELEN] = a | b;
        vfu_pkg::VFU_XOR:  res[i*`VFU_ELEN +: `VFU_ELEN] = a ^ b;
        vfu_pkg::VFU_MIN:  res[i*`VFU_ELEN +: `VFU_ELEN] = ($signed(a) < $signed(b)) ? a : b;
        vfu_pkg::VFU_MAXU: res[i*`VFU_ELEN +: `VFU_ELEN] = (a > b) ? a : b;
        vfu_pkg::VFU_SLL:  res[i*`VFU_ELEN +: `VFU_ELEN] = a << b[$clog2(`VFU_ELEN)-1:0];
      endcase
      // One enable per byte of a live lane
      be[i*(`VFU_ELEN/8) +: `VFU_ELEN/8] = {(`VFU_ELEN/8){issue_i.lanes[i]}};
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  assign issue_i.ready = !out_valid_q || result_o.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (issue_i.ready) begin
      out_valid_q <= issue_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i.valid && issue_i.ready) begin
      data_q  <= res;
      be_q    <= be;
      waddr_q <= issue_i.waddr;
      id_q    <= issue_i.id;
      last_q  <= issue_i.last;
    end
  end

  assign result_o.valid = out_valid_q;
  assign result_o.data  = data_q;
  assign result_o.be    = be_q;
  assign result_o.waddr = waddr_q;
  assign result_o.id    = id_q;
  assign result_o.last  = last_q;

endmodule

// File: source/vfu_result_fifo.sv
`timescale 1ns/1ps
`include "vfu_settings.svh"

module vfu_result_fifo (
  input  logic       clk_i,
  input  logic       rst_n_i,
  vfu_result_if.dst  push_i,
  vfu_result_if.src  pop_o
);

  typedef logic [$clog2(`VFU_FIFO_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(`VFU_FIFO_DEPTH+1)-1:0] count_t;

  // Entry storage
  vfu_pkg::word_t      data_mem  [`VFU_FIFO_DEPTH];
  vfu_pkg::be_t        be_mem    [`VFU_FIFO_DEPTH];
  vfu_pkg::vreg_addr_t waddr_mem [`VFU_FIFO_DEPTH];
  vfu_pkg::insn_id_t   id_mem    [`VFU_FIFO_DEPTH];
  logic                last_mem  [`VFU_FIFO_DEPTH];

  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  count_t count_q;
  logic   push;
  logic   pop;

  assign push_i.ready = count_q != count_t'(`VFU_FIFO_DEPTH);
  assign pop_o.valid  = count_q != '0;
  assign push = push_i.valid && push_i.ready;
  assign pop  = pop_o.valid && pop_o.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == ptr_t'(`VFU_FIFO_DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == ptr_t'(`VFU_FIFO_DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wr_ptr_q]  <= push_i.data;
      be_mem[wr_ptr_q]    <= push_i.be;
      waddr_mem[wr_ptr_q] <= push_i.waddr;
      id_mem[wr_ptr_q]    <= push_i.id;
      last_mem[wr_ptr_q]  <= push_i.last;
    end
  end

  // Head of queue
  assign pop_o.data  = data_mem[rd_ptr_q];
  assign pop_o.be    = be_mem[rd_ptr_q];
  assign pop_o.waddr = waddr_mem[rd_ptr_q];
  assign pop_o.id    = id_mem[rd_ptr_q];
  assign pop_o.last  = last_mem[rd_ptr_q];

endmodule

// File: source/vfu_writeback.sv
`timescale 1ns/1ps

module vfu_writeback (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  vfu_result_if.dst            result_i,
  // VRF write port
  output logic                 vrf_we_o,
  output vfu_pkg::vreg_addr_t  vrf_waddr_o,
  output vfu_pkg::word_t       vrf_wdata_o,
  output vfu_pkg::be_t         vrf_wbe_o,
  input  logic                 vrf_wvalid_i,
  // Instruction completion
  output logic                 rsp_valid_o,
  output vfu_pkg::insn_id_t    rsp_id_o
);

  logic wr_done;

  ////////////////////
  // VRF write
  ////////////////////

  // Head entry stays on the port until the VRF takes it
  assign vrf_we_o    = result_i.valid;
  assign vrf_waddr_o = result_i.waddr;
  assign vrf_wdata_o = result_i.data;
  assign vrf_wbe_o   = result_i.be;

  assign wr_done        = result_i.valid && vrf_wvalid_i;
  assign result_i.ready = wr_done;

  ////////////////////
  // Response
  ////////////////////

  // One-cycle pulse after the final word lands
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= wr_done && result_i.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_done && result_i.last) begin
      rsp_id_o <= result_i.id;
    end
  end

endmodule

// File: source/vfu_top.sv
`timescale 1ns/1ps

module vfu_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Request
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  vfu_pkg::vfu_op_e           req_op_i,
  input  vfu_pkg::vreg_t             req_vs1_i,
  input  vfu_pkg::vreg_t             req_vs2_i,
  input  vfu_pkg::vreg_t             req_vd_i,
  input  logic                       req_use_rs1_i,
  input  vfu_pkg::elem_t             req_rs1_i,
  input  vfu_pkg::vl_t               req_vl_i,
  input  vfu_pkg::insn_id_t          req_id_i,
  // VRF reads
  output logic                 [1:0] vrf_re_o,
  output vfu_pkg::vreg_addr_t  [1:0] vrf_raddr_o,
  input  logic                 [1:0] vrf_rvalid_i,
  input  vfu_pkg::word_t       [1:0] vrf_rdata_i,
  // VRF write
  output logic                       vrf_we_o,
  output vfu_pkg::vreg_addr_t        vrf_waddr_o,
  output vfu_pkg::word_t             vrf_wdata_o,
  output vfu_pkg::be_t               vrf_wbe_o,
  input  logic                       vrf_wvalid_i,
  // Response
  output logic                       rsp_valid_o,
  output vfu_pkg::insn_id_t          rsp_id_o
);

  vfu_issue_if  issue_bus ();
  vfu_result_if lane_res ();
  vfu_result_if wb_res ();

  vfu_sequencer u_sequencer (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .req_vs1_i     (req_vs1_i),
    .req_vs2_i     (req_vs2_i),
    .req_vd_i      (req_vd_i),
    .req_use_rs1_i (req_use_rs1_i),
    .req_rs1_i     (req_rs1_i),
    .req_vl_i      (req_vl_i),
    .req_id_i      (req_id_i),
    .vrf_re_o      (vrf_re_o),
    .vrf_raddr_o   (vrf_raddr_o),
    .vrf_rvalid_i  (vrf_rvalid_i),
    .vrf_rdata_i   (vrf_rdata_i),
    .issue_o       (issue_bus)
  );

  vfu_ipu u_ipu (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .issue_i  (issue_bus),
    .result_o (lane_res)
  );

  // Absorbs write stalls before they reach the lanes
  vfu_result_fifo u_result_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (lane_res),
    .pop_o   (wb_res)
  );

  vfu_writeback u_writeback (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .result_i     (wb_res),
    .vrf_we_o     (vrf_we_o),
    .vrf_waddr_o  (vrf_waddr_o),
    .vrf_wdata_o  (vrf_wdata_o),
    .vrf_wbe_o    (vrf_wbe_o),
    .vrf_wvalid_i (vrf_wvalid_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_id_o     (rsp_id_o)
  );

endmodule

// File: dv/vfu_properties.sv
`timescale 1ns/1ps

module vfu_properties (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                 [1:0] re_i,
  input  vfu_pkg::vreg_addr_t  [1:0] raddr_i,
  input  logic                 [1:0] rvalid_i,
  input  logic                       we_i,
  input  vfu_pkg::vreg_addr_t        waddr_i,
  input  vfu_pkg::word_t             wdata_i,
  input  vfu_pkg::be_t               wbe_i,
  input  logic                       wvalid_i,
  input  logic                       rsp_valid_i
);

  int fail_count;

  ////////////////////
  // VRF handshakes
  ////////////////////

  // Port 0 reads vs2
  read0_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    re_i[0] && !rvalid_i[0] |=> re_i[0] && $stable(raddr_i[0]))
    else begin
      $error("read port 0 request changed before rvalid");
      fail_count++;
    end

  // Port 1 reads vs1
  read1_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    re_i[1] && !rvalid_i[1] |=> re_i[1] && $stable(raddr_i[1]))
    else begin
      $error("read port 1 request changed before rvalid");
      fail_count++;
    end

  write_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    we_i && !wvalid_i |=> we_i && $stable(waddr_i) && $stable(wdata_i) && $stable(wbe_i))
    else begin
      $error("write payload changed before wvalid");
      fail_count++;
    end

  ////////////////////
  // Response and reset
  ////////////////////

  rsp_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |=> !rsp_valid_i)
    else begin
      $error("response valid lasted two cycles");
      fail_count++;
    end

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i && $past(!rst_n_i) |-> re_i == 2'b00 && !we_i && !rsp_valid_i)
    else begin
      $error("enable raised while in reset");
      fail_count++;
    end

endmodule

// File: dv/vfu_checker.sv
`timescale 1ns/1ps
`include "vfu_settings.svh"

module vfu_checker (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  input  logic                 req_ready_i,
  input  vfu_pkg::vfu_op_e     req_op_i,
  input  vfu_pkg::vreg_t       req_vs1_i,
  input  vfu_pkg::vreg_t       req_vs2_i,
  input  vfu_pkg::vreg_t       req_vd_i,
  input  logic                 req_use_rs1_i,
  input  vfu_pkg::elem_t       req_rs1_i,
  input  vfu_pkg::vl_t         req_vl_i,
  input  vfu_pkg::insn_id_t    req_id_i,
  input  logic           [1:0] vrf_re_i,
  input  logic                 vrf_we_i,
  input  vfu_pkg::vreg_addr_t  vrf_waddr_i,
  input  vfu_pkg::word_t       vrf_wdata_i,
  input  vfu_pkg::be_t         vrf_wbe_i,
  input  logic                 vrf_wvalid_i,
  input  logic                 rsp_valid_i,
  input  vfu_pkg::insn_id_t    rsp_id_i,
  output int                   wr_err_o,
  output int                   rsp_err_o,
  output int                   rd_err_o,
  output int                   rst_err_o,
  output int                   pending_o,
  output int                   rsp_count_o
);

  localparam int FILL_SEED = 32'hec34;
  localparam int ELEN      = `VFU_ELEN;
  localparam int NL        = `VFU_N_LANES;
  localparam int WPV       = `VFU_WORDS_PER_VREG;
  localparam int N_WORDS   = `VFU_NR_VREGS * `VFU_WORDS_PER_VREG;

  // Initial VRF contents from the same sequence as the VRF model
  vfu_pkg::word_t      init_mem [N_WORDS];
  integer              seed;
  vfu_pkg::vreg_addr_t exp_addr [$];
  vfu_pkg::word_t      exp_data [$];
  vfu_pkg::be_t        exp_be   [$];
  bit                  exp_last [$];
  vfu_pkg::insn_id_t   exp_id   [$];
  bit                  cur_use_rs1;
  bit                  rsp_due;
  vfu_pkg::insn_id_t   rsp_id_due;
  bit                  in_reset_q;

  initial begin : fill_proc
    seed = FILL_SEED;
    for (int a = 0; a < N_WORDS; a++) begin
      for (int l = 0; l < NL; l++) begin
        init_mem[a][l*ELEN +: ELEN] = $random(seed);
      end
    end
  end

  // Operand a is vs1 or the scalar and b is vs2
  function automatic vfu_pkg::elem_t lane_result(input vfu_pkg::vfu_op_e op,
                                                 input vfu_pkg::elem_t a,
                                                 input vfu_pkg::elem_t b);
    case (op)
      vfu_pkg::VFU_ADD:  return a + b;
      vfu_pkg::VFU_SUB:  return a - b;
      vfu_pkg::VFU_AND:  return a & b;
      vfu_pkg::VFU_OR:   return a | b;
      vfu_pkg::VFU_XOR:  return a ^ b;
      vfu_pkg::VFU_MIN:  return ($signed(a) < $signed(b)) ? a : b;
      vfu_pkg::VFU_MAXU: return (a > b) ? a : b;
      vfu_pkg::VFU_SLL:  return a << b[4:0];
      default:           return 'x;
    endcase
  endfunction

  function automatic bit differs(input string name, input logic [127:0] exp,
                                 input logic [127:0] got);
    if (exp !== got) begin
      $display("CHECK FAILED %s expected %h observed %h", name, exp, got);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  ////////////////////
  // Expected writes
  ////////////////////

  task automatic queue_request();
    vfu_pkg::word_t data;
    vfu_pkg::be_t   be;
    vfu_pkg::elem_t a;
    vfu_pkg::elem_t b;
    int             n_words;
    n_words = (req_vl_i + NL - 1) / NL;
    for (int k = 0; k < n_words; k++) begin
      data = '0;
      be   = '0;
      for (int l = 0; l < NL; l++) begin
        b = init_mem[req_vs2_i * WPV + k][l*ELEN +: ELEN];
        a = req_use_rs1_i ? req_rs1_i : init_mem[req_vs1_i * WPV + k][l*ELEN +: ELEN];
        data[l*ELEN +: ELEN] = lane_result(req_op_i, a, b);
        if (k * NL + l < req_vl_i) be[l*ELEN/8 +: ELEN/8] = '1;
      end
      exp_addr.push_back(vfu_pkg::vreg_addr_t'(req_vd_i * WPV + k));
      exp_data.push_back(data);
      exp_be.push_back(be);
      exp_last.push_back(k == n_words - 1);
      exp_id.push_back(req_id_i);
    end
  endtask

  task automatic check_write();
    vfu_pkg::word_t mask;
    if (exp_addr.size() == 0) begin
      $display("Unexpected VRF write to address %h", vrf_waddr_i);
      wr_err_o++;
    end else begin
      mask = '0;
      for (int b = 0; b < NL * ELEN / 8; b++) begin
        if (exp_be[0][b]) mask[b*8 +: 8] = 8'hff;
      end
      wr_err_o += differs("vrf_waddr_o", exp_addr[0], vrf_waddr_i);
      wr_err_o += differs("vrf_wbe_o", exp_be[0], vrf_wbe_i);
      wr_err_o += differs("vrf_wdata_o", exp_data[0] & mask, vrf_wdata_i & mask);
      if (exp_last[0]) begin
        rsp_due    = 1'b1;
        rsp_id_due = exp_id[0];
      end
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      void'(exp_be.pop_front());
      void'(exp_last.pop_front());
      void'(exp_id.pop_front());
    end
  endtask

  ////////////////////
  // Compare at each edge
  ////////////////////

  always @(posedge clk_i) begin : compare_proc
    bit due_now;
    due_now = rsp_due;
    rsp_due = 1'b0;
    // Outputs sampled here still hold their values from the previous edge
    if (in_reset_q) begin
      if (vrf_re_i !== 2'b00 || vrf_we_i !== 1'b0 || rsp_valid_i !== 1'b0
          || req_ready_i !== 1'b1) begin
        $display("Interface not idle during or right after reset");
        rst_err_o++;
      end
    end
    in_reset_q = !rst_n_i;
    if (rst_n_i) begin
      if (rsp_valid_i) rsp_count_o++;
      if (due_now) begin
        if (!rsp_valid_i) begin
          $display("Response missing in the cycle after the final write");
          rsp_err_o++;
        end else begin
          rsp_err_o += differs("rsp_id_o", rsp_id_due, rsp_id_i);
        end
      end else if (rsp_valid_i) begin
        $display("Response without a completed instruction");
        rsp_err_o++;
      end
      if (vrf_re_i[1] && cur_use_rs1) begin
        $display("vs1 read port used by a scalar operand request");
        rd_err_o++;
      end
      if (vrf_we_i && vrf_wvalid_i) check_write();
      if (req_valid_i && req_ready_i) begin
        queue_request();
        cur_use_rs1 = req_use_rs1_i;
      end
    end
    pending_o = exp_addr.size();
  end

endmodule

// File: dv/tb_vfu.sv
`timescale 1ns/1ps
`include "vfu_settings.svh"

module tb_vfu;

  localparam int N_ENTRIES      = 12;
  localparam int SEED           = 32'hec34;
  localparam int TIMEOUT_FACTOR = 40;
  localparam int STALL_PCT      = 25;
  localparam int TIMEOUT_CYCLES = N_ENTRIES * 16 * TIMEOUT_FACTOR;
  localparam int N_WORDS        = `VFU_NR_VREGS * `VFU_WORDS_PER_VREG;
  localparam int BE_W           = `VFU_N_LANES * `VFU_ELEN / 8;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      req_valid_i;
  logic                      req_ready_o;
  vfu_pkg::vfu_op_e          req_op_i;
  vfu_pkg::vreg_t            req_vs1_i;
  vfu_pkg::vreg_t            req_vs2_i;
  vfu_pkg::vreg_t            req_vd_i;
  logic                      req_use_rs1_i;
  vfu_pkg::elem_t            req_rs1_i;
  vfu_pkg::vl_t              req_vl_i;
  vfu_pkg::insn_id_t         req_id_i;
  logic                [1:0] vrf_re_o;
  vfu_pkg::vreg_addr_t [1:0] vrf_raddr_o;
  logic                [1:0] vrf_rvalid_i;
  vfu_pkg::word_t      [1:0] vrf_rdata_i;
  logic                      vrf_we_o;
  vfu_pkg::vreg_addr_t       vrf_waddr_o;
  vfu_pkg::word_t            vrf_wdata_o;
  vfu_pkg::be_t              vrf_wbe_o;
  logic                      vrf_wvalid_i;
  logic                      rsp_valid_o;
  vfu_pkg::insn_id_t         rsp_id_o;

  // Stimulus table columns
  vfu_pkg::vfu_op_e  t_op      [N_ENTRIES];
  vfu_pkg::vreg_t    t_vs1     [N_ENTRIES];
  vfu_pkg::vreg_t    t_vs2     [N_ENTRIES];
  vfu_pkg::vreg_t    t_vd      [N_ENTRIES];
  bit                t_use_rs1 [N_ENTRIES];
  vfu_pkg::elem_t    t_rs1     [N_ENTRIES];
  vfu_pkg::vl_t      t_vl      [N_ENTRIES];
  vfu_pkg::insn_id_t t_id      [N_ENTRIES];
  int                n_loaded;

  vfu_pkg::word_t vrf_mem [N_WORDS];
  integer         seed;
  int             rd_wait [2];
  int             wr_errs, rsp_errs, rd_errs, rst_errs, pending, rsp_count, end_errs;

  vfu_top dut0 (.*);

  vfu_checker checker0 (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .req_valid_i (req_valid_i), .req_ready_i (req_ready_o), .req_op_i (req_op_i),
    .req_vs1_i (req_vs1_i), .req_vs2_i (req_vs2_i), .req_vd_i (req_vd_i),
    .req_use_rs1_i (req_use_rs1_i), .req_rs1_i (req_rs1_i), .req_vl_i (req_vl_i),
    .req_id_i (req_id_i), .vrf_re_i (vrf_re_o), .vrf_we_i (vrf_we_o),
    .vrf_waddr_i (vrf_waddr_o), .vrf_wdata_i (vrf_wdata_o), .vrf_wbe_i (vrf_wbe_o),
    .vrf_wvalid_i (vrf_wvalid_i), .rsp_valid_i (rsp_valid_o), .rsp_id_i (rsp_id_o),
    .wr_err_o (wr_errs), .rsp_err_o (rsp_errs), .rd_err_o (rd_errs),
    .rst_err_o (rst_errs), .pending_o (pending), .rsp_count_o (rsp_count)
  );

  bind vfu_top vfu_properties props0 (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .re_i (vrf_re_o), .raddr_i (vrf_raddr_o), .rvalid_i (vrf_rvalid_i),
    .we_i (vrf_we_o), .waddr_i (vrf_waddr_o), .wdata_i (vrf_wdata_o),
    .wbe_i (vrf_wbe_o), .wvalid_i (vrf_wvalid_i), .rsp_valid_i (rsp_valid_o)
  );

  always #4 clk_i = ~clk_i;

  task automatic add_entry(input vfu_pkg::vfu_op_e op, input int vs1, input int vs2,
                           input int vd, input bit use_rs1, input vfu_pkg::elem_t rs1,
                           input int vl, input int id);
    t_op[n_loaded]      = op;
    t_vs1[n_loaded]     = vfu_pkg::vreg_t'(vs1);
    t_vs2[n_loaded]     = vfu_pkg::vreg_t'(vs2);
    t_vd[n_loaded]      = vfu_pkg::vreg_t'(vd);
    t_use_rs1[n_loaded] = use_rs1;
    t_rs1[n_loaded]     = rs1;
    t_vl[n_loaded]      = vfu_pkg::vl_t'(vl);
    t_id[n_loaded]      = vfu_pkg::insn_id_t'(id);
    n_loaded++;
  endtask

  // Holds valid until the edge that sees ready high
  task automatic send_request(input int i);
    bit accepted;
    req_valid_i   = 1'b1;
    req_op_i      = t_op[i];
    req_vs1_i     = t_vs1[i];
    req_vs2_i     = t_vs2[i];
    req_vd_i      = t_vd[i];
    req_use_rs1_i = t_use_rs1[i];
    req_rs1_i     = t_rs1[i];
    req_vl_i      = t_vl[i];
    req_id_i      = t_id[i];
    accepted      = 1'b0;
    while (!accepted) begin
      accepted = req_ready_o;
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
  endtask

  task automatic finish_run(input bit timed_out);
    int total;
    int assert_errs;
    assert_errs = dut0.props0.fail_count;
    total = wr_errs + rsp_errs + rd_errs + rst_errs + end_errs + assert_errs;
    $display("Errors: write %0d, response %0d, read %0d, reset %0d, assert %0d, end of run %0d",
             wr_errs, rsp_errs, rd_errs, rst_errs, assert_errs, end_errs);
    if (!timed_out && total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  ////////////////////
  // VRF model
  ////////////////////

  always @(posedge clk_i) begin : read_model
    logic                [1:0] re_s;
    logic                [1:0] done;
    vfu_pkg::vreg_addr_t [1:0] addr_s;
    re_s   = vrf_re_o;
    done   = vrf_re_o & vrf_rvalid_i;
    addr_s = vrf_raddr_o;
    #1;
    for (int p = 0; p < 2; p++) begin
      if (!rst_n_i || !re_s[p] || done[p]) begin
        vrf_rvalid_i[p] = 1'b0;
        rd_wait[p]      = 0;
      end else if (!vrf_rvalid_i[p]) begin
        // One to three cycles after the request is seen
        if (rd_wait[p] == 0) rd_wait[p] = 1 + {$random(seed)} % 3;
        rd_wait[p]--;
        if (rd_wait[p] == 0) begin
          vrf_rvalid_i[p] = 1'b1;
          vrf_rdata_i[p]  = vrf_mem[addr_s[p]];
        end
      end
    end
  end

  always @(posedge clk_i) begin : write_model
    bit stall;
    if (vrf_we_o && vrf_wvalid_i) begin
      for (int b = 0; b < BE_W; b++) begin
        if (vrf_wbe_o[b]) vrf_mem[vrf_waddr_o][b*8 +: 8] = vrf_wdata_o[b*8 +: 8];
      end
    end
    #1;
    stall        = {$random(seed)} % 100 < STALL_PCT;
    vrf_wvalid_i = rst_n_i && !stall;
  end

  initial begin : watchdog_proc
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Run timed out after %0d cycles", TIMEOUT_CYCLES);
    finish_run(1'b1);
  end

  initial begin : main_proc
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_op_i = vfu_pkg::VFU_ADD;
    req_vs1_i = '0;
    req_vs2_i = '0;
    req_vd_i = '0;
    req_use_rs1_i = 1'b0;
    req_rs1_i = '0;
    req_vl_i = '0;
    req_id_i = '0;
    vrf_rvalid_i = '0;
    vrf_rdata_i = '0;
    vrf_wvalid_i = 1'b0;
    end_errs = 0;
    n_loaded = 0;
    seed = SEED;
    for (int a = 0; a < N_WORDS; a++) begin
      for (int l = 0; l < `VFU_N_LANES; l++) begin
        vrf_mem[a][l*`VFU_ELEN +: `VFU_ELEN] = $random(seed);
      end
    end
    // op, vs1, vs2, vd, use_rs1, rs1, vl, id
    // Sources stay in v0..v15 and destinations in v20..v31
    add_entry(vfu_pkg::VFU_ADD,   1,  2, 20, 1'b0, 32'h0,         16, 0);
    add_entry(vfu_pkg::VFU_SUB,   3,  4, 21, 1'b0, 32'h0,         16, 1);
    add_entry(vfu_pkg::VFU_AND,   5,  6, 22, 1'b0, 32'h0,         16, 2);
    add_entry(vfu_pkg::VFU_OR,    7,  8, 23, 1'b0, 32'h0,         16, 3);
    add_entry(vfu_pkg::VFU_XOR,   9, 10, 24, 1'b0, 32'h0,         16, 4);
    add_entry(vfu_pkg::VFU_MIN,  11, 12, 25, 1'b0, 32'h0,         16, 5);
    add_entry(vfu_pkg::VFU_MAXU, 13, 14, 26, 1'b0, 32'h0,         16, 6);
    add_entry(vfu_pkg::VFU_SLL,  15,  0, 27, 1'b0, 32'h0,         16, 7);
    add_entry(vfu_pkg::VFU_ADD,   0,  1, 28, 1'b1, 32'h0000_1234, 16, 0);
    add_entry(vfu_pkg::VFU_SLL,   0,  2, 29, 1'b1, 32'h0000_0001,  7, 1);
    add_entry(vfu_pkg::VFU_XOR,   3,  4, 30, 1'b0, 32'h0,          5, 2);
    add_entry(vfu_pkg::VFU_MIN,   0,  5, 31, 1'b1, 32'h8000_0005,  1, 3);
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    for (int i = 0; i < N_ENTRIES; i++) begin
      send_request(i);
    end
    while (rsp_count < N_ENTRIES) begin
      @(posedge clk_i);
      #1;
    end
    // Room for any stray write or response
    repeat (20) @(posedge clk_i);
    #1;
    if (pending != 0) begin
      $display("%0d expected VRF writes never happened", pending);
      end_errs++;
    end
    if (rsp_count != N_ENTRIES) begin
      $display("Saw %0d responses for %0d requests", rsp_count, N_ENTRIES);
      end_errs++;
    end
    finish_run(1'b0);
  end

endmodule

// File: sim.f
+incdir+source
source/vfu_pkg.sv
source/vfu_if.sv
source/vfu_sequencer.sv
source/vfu_ipu.sv
source/vfu_result_fifo.sv
source/vfu_writeback.sv
source/vfu_top.sv
dv/vfu_properties.sv
dv/vfu_checker.sv
dv/tb_vfu.sv

// File: Bender.yml
package:
  name: vfu

sources:
  - include_dirs:
      - source
    files:
      - source/vfu_pkg.sv
      - source/vfu_if.sv
      - source/vfu_sequencer.sv
      - source/vfu_ipu.sv
      - source/vfu_result_fifo.sv
      - source/vfu_writeback.sv
      - source/vfu_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/vfu_properties.sv
      - dv/vfu_checker.sv
      - dv/tb_vfu.sv
